/* bench/pong_input.txt */
# hold up dn ctrl p1_row lit
# hold: frames held, 0 random idle length, negative a short press in cycles
# p1_row -1 not checked, lit -1 at least two paddles per frame
# demo in IDLE
0 0 0 0 -1 -1
0 0 0 0 -1 -1
# serve, a ctrl glitch, then up held while still in START
1 0 0 1 20 -1
2 0 0 0 20 48
-6 0 0 1 20 48
2 1 0 0 20 48
# play, up then down until the ball passes the right edge
1 0 0 1 20 48
3 1 0 0 14 48
2 0 1 0 18 48
# point end freezes the paddle
2 1 0 0 18 48
# second serve and play
1 0 0 1 20 48
1 0 0 1 20 48
2 0 1 0 24 48
1 1 0 0 22 48

/* sources.f */
rtl/display_pkg.sv
rtl/game_pkg.sv
rtl/display_timings.sv
rtl/debounce.sv
rtl/game_fsm.sv
rtl/paddle_motion.sv
rtl/ball_motion.sv
rtl/pixel_render.sv
rtl/top_pong.sv
bench/tb_pong.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_pong
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= NO ERRORS
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM) bench/pong_input.txt
	-./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/tb_pong.sv */
////////////////////////////////////////
// Pong core testbench, script driven
// with per-frame picture capture
////////////////////////////////////////

module tb_pong import display_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int h_res        = 64;
    localparam int v_res        = 48;
    localparam int h_full       = 80;
    localparam int v_full       = 54;
    localparam int h_sync_start = 65;
    localparam int h_sync_end   = 74;
    localparam int v_sync_start = 49;
    localparam int v_sync_end   = 51;
    localparam int deb_cycles   = 8;
    localparam int b_size       = 4;
    localparam int p_h          = 8;
    localparam int p_w          = 2;
    localparam int p_sp         = 2;
    localparam int p_offs       = 4;
    localparam int min_lit      = 2 * p_h * p_w;   // two paddles as the ball may hide in one
    localparam int frame_limit  = 2 * h_full * v_full;

    logic    clk_pix, rst_n, btn_up, btn_dn, btn_ctrl;
    logic    dvi_hsync, dvi_vsync, dvi_de;
    colour_t dvi_r, dvi_g, dvi_b;

    int          frame_cnt, last_lit, last_p1_row;  // results of the last full frame
    int          col, line_cnt, lit_cnt, p1_row_cur, hs_run, vs_run;
    logic        de_prev, hs_prev, vs_prev;
    int unsigned rng;

    top_pong #(
        .h_res(h_res), .v_res(v_res), .h_full(h_full), .v_full(v_full),
        .h_sync_start(h_sync_start), .h_sync_end(h_sync_end),
        .v_sync_start(v_sync_start), .v_sync_end(v_sync_end),
        .deb_cycles(deb_cycles), .b_size(b_size), .p_h(p_h), .p_w(p_w),
        .p_sp(p_sp), .p_offs(p_offs)
    ) i_dut (
        .clk_pix, .rst_n, .btn_up, .btn_dn, .btn_ctrl,
        .dvi_hsync, .dvi_vsync, .dvi_de, .dvi_r, .dvi_g, .dvi_b
    );

    initial begin
        clk_pix = 1'b0;
        forever #2 clk_pix = ~clk_pix;
    end

    task automatic stop_on_failure();
        $display("ERRORS FOUND");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic check_value(input int actual, input int expected, input string what);
        if (actual != expected) begin
            $display("[ERROR] %0d ns: %s, got %0d, expected %0d", $time, what, actual, expected);
            stop_on_failure();
        end
    endtask

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // called just after a rising edge
    task automatic drive_buttons(input int up, input int dn, input int ctrl);
        #1;
        btn_up   = (up != 0);
        btn_dn   = (dn != 0);
        btn_ctrl = (ctrl != 0);
    endtask

    task automatic wait_frame(output int lit, output int row);
        int start;
        int n;
        start = frame_cnt;
        n     = 0;
        while (frame_cnt == start && n < frame_limit) begin
            @(posedge clk_pix);
            n++;
        end
        if (frame_cnt == start) begin
            $display("timeout: no vsync frame boundary within %0d cycles", frame_limit);
            stop_on_failure();
        end else begin
            lit = last_lit;
            row = last_p1_row;
        end
    endtask

    // hold the buttons, release them and let one settle frame show the last update
    task automatic run_step(input int hold, input int up, input int dn, input int ctrl,
                            input int exp_row, input int exp_lit);
        int frames;
        int lit;
        int row;
        frames = hold;
        if (hold == 0) begin
            rng    = lcg_next(rng);
            frames = 2 + int'((rng >> 16) % 4);  // random idle length
        end
        drive_buttons(up, dn, ctrl);
        if (hold < 0) begin
            repeat (-hold) @(posedge clk_pix);  // short press in cycles
            frames = 0;
        end
        for (int i = 0; i <= frames; i++) begin
            if (i == frames) drive_buttons(0, 0, 0);
            wait_frame(lit, row);
            if (exp_lit < 0) begin
                check_value(int'(lit >= min_lit), 1,
                            "frame shows fewer lit pixels than two paddles");
            end else begin
                check_value(lit, exp_lit, "lit pixels in frame");
            end
        end
        if (exp_row >= 0) check_value(row, exp_row, "paddle 1 top row");
    endtask

    // raster and picture monitor on the falling edge
    always @(negedge clk_pix) begin
        if (!rst_n) begin
            de_prev     = 1'b0;
            hs_prev     = 1'b1;
            vs_prev     = 1'b1;
            col         = 0;
            line_cnt    = 0;
            lit_cnt     = 0;
            hs_run      = 0;
            vs_run      = 0;
            p1_row_cur  = -1;
            frame_cnt   = 0;
            last_lit    = 0;
            last_p1_row = -1;
        end else begin
            if (dvi_de) begin
                if ({dvi_r, dvi_g, dvi_b} == 12'hfff) begin
                    lit_cnt++;
                    if (col >= p_offs && col < p_offs + p_w && p1_row_cur < 0) begin
                        p1_row_cur = line_cnt;  // left paddle top
                    end
                end else begin
                    check_value(int'({dvi_r, dvi_g, dvi_b}), 0, "pixel neither black nor white");
                end
                col++;
            end else begin
                check_value(int'({dvi_r, dvi_g, dvi_b}), 0, "colour outside active area");
                if (de_prev) begin
                    check_value(col, h_res, "active pixels per line");
                    line_cnt++;
                    col = 0;
                end
            end
            if (!dvi_hsync) begin
                hs_run++;
            end else if (!hs_prev) begin
                check_value(hs_run, h_sync_end - h_sync_start, "hsync low cycles per line");
                hs_run = 0;
            end
            if (!dvi_vsync) begin
                vs_run++;
            end else if (!vs_prev) begin
                check_value(vs_run, (v_sync_end - v_sync_start) * h_full, "vsync low cycles");
                vs_run = 0;
            end
            if (!dvi_vsync && vs_prev) begin  // frame boundary
                check_value(line_cnt, v_res, "active lines per frame");
                last_lit    = lit_cnt;
                last_p1_row = p1_row_cur;
                frame_cnt++;
                line_cnt    = 0;
                lit_cnt     = 0;
                p1_row_cur  = -1;
            end
            de_prev = dvi_de;
            hs_prev = dvi_hsync;
            vs_prev = dvi_vsync;
        end
    end

    initial begin
        int    fd;
        int    n;
        int    hold, up, dn, ctrl, exp_row, exp_lit;
        string line;
        rst_n    = 1'b0;
        btn_up   = 1'b0;
        btn_dn   = 1'b0;
        btn_ctrl = 1'b0;
        rng      = 57;
        repeat (4) @(posedge clk_pix);
        @(negedge clk_pix);
        check_value(int'(dvi_hsync), 1, "hsync during reset");
        check_value(int'(dvi_vsync), 1, "vsync during reset");
        check_value(int'(dvi_de), 0, "data enable during reset");
        check_value(int'({dvi_r, dvi_g, dvi_b}), 0, "colour during reset");
        @(posedge clk_pix);
        #1;
        rst_n = 1'b1;
        @(negedge clk_pix);
        check_value(int'(dvi_hsync), 1, "hsync right after reset");
        check_value(int'(dvi_vsync), 1, "vsync right after reset");
        @(posedge clk_pix);
        fd = $fopen("bench/pong_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file bench/pong_input.txt");
            stop_on_failure();
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%d %d %d %d %d %d",
                                hold, up, dn, ctrl, exp_row, exp_lit);
                    if (n == 6) run_step(hold, up, dn, ctrl, exp_row, exp_lit);
                end
            end
            $fclose(fd);
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

/* rtl/top_pong.sv */
////////////////////////////////////////
// Pong game core for 12-bit DVI
////////////////////////////////////////

module top_pong import display_pkg::*, game_pkg::*; #(
    parameter int h_res        = 640,
    parameter int v_res        = 480,
    parameter int h_full       = 800,
    parameter int v_full       = 525,
    parameter int h_sync_start = h_res + (h_full - h_res) / 10,
    parameter int h_sync_end   = h_sync_start + (h_full - h_res) * 3 / 5,
    parameter int v_sync_start = v_res + (v_full - v_res) * 2 / 9,
    parameter int v_sync_end   = v_sync_start + 2,
    parameter int deb_cycles   = 2**17,
    parameter int b_size       = 8,
    parameter int p_h          = 40,
    parameter int p_w          = 10,
    parameter int p_sp         = 4,
    parameter int p_offs       = 32,
    parameter int speed_step   = 5
) (
    input  logic    clk_pix,
    input  logic    rst_n,
    input  logic    btn_up,
    input  logic    btn_dn,
    input  logic    btn_ctrl,
    output logic    dvi_hsync,
    output logic    dvi_vsync,
    output logic    dvi_de,
    output colour_t dvi_r,
    output colour_t dvi_g,
    output colour_t dvi_b
);

    cord_t       sx, sy, bx, by, p1y, p2y;
    logic        hsync, vsync, de, animate;
    logic        move_up, move_dn, ctrl_rel;
    logic        lft_col, rgt_col, p1_col, p2_col;
    game_state_t state;

    display_timings #(
        .h_res(h_res), .v_res(v_res), .h_full(h_full), .v_full(v_full),
        .h_sync_start(h_sync_start), .h_sync_end(h_sync_end),
        .v_sync_start(v_sync_start), .v_sync_end(v_sync_end)
    ) i_timings (
        .clk_pix, .rst_n, .sx, .sy, .hsync, .vsync, .de, .animate
    );

    debounce #(.deb_cycles(deb_cycles)) i_deb_up (
        .clk_pix, .rst_n, .btn(btn_up), .level(move_up), .rel()
    );

    debounce #(.deb_cycles(deb_cycles)) i_deb_dn (
        .clk_pix, .rst_n, .btn(btn_dn), .level(move_dn), .rel()
    );

    debounce #(.deb_cycles(deb_cycles)) i_deb_ctrl (
        .clk_pix, .rst_n, .btn(btn_ctrl), .level(), .rel(ctrl_rel)
    );

    game_fsm i_fsm (
        .clk_pix, .rst_n, .ctrl_rel, .lft_col, .rgt_col, .state
    );

    paddle_motion #(
        .v_res(v_res), .p_h(p_h), .p_sp(p_sp), .b_size(b_size)
    ) i_paddles (
        .clk_pix, .rst_n, .animate, .move_up, .move_dn, .state, .by, .p1y, .p2y
    );

    ball_motion #(
        .h_res(h_res), .v_res(v_res), .b_size(b_size), .p_h(p_h),
        .speed_step(speed_step)
    ) i_ball (
        .clk_pix, .rst_n, .animate, .p1_col, .p2_col, .state, .p1y,
        .bx, .by, .lft_col, .rgt_col
    );

    pixel_render #(
        .h_res(h_res), .b_size(b_size), .p_h(p_h), .p_w(p_w), .p_offs(p_offs)
    ) i_render (
        .clk_pix, .rst_n, .animate, .de, .sx, .sy, .bx, .by, .p1y, .p2y,
        .hsync_in(hsync), .vsync_in(vsync), .p1_col, .p2_col,
        .dvi_hsync, .dvi_vsync, .dvi_de, .dvi_r, .dvi_g, .dvi_b
    );

endmodule

/* rtl/pixel_render.sv */
////////////////////////////////////////
// object coverage, paddle hit latches
// and registered DVI outputs
////////////////////////////////////////

module pixel_render import display_pkg::*; #(
    parameter int h_res  = 640,
    parameter int b_size = 8,
    parameter int p_h    = 40,
    parameter int p_w    = 10,
    parameter int p_offs = 32
) (
    input  logic    clk_pix,
    input  logic    rst_n,
    input  logic    animate,
    input  logic    de,
    input  cord_t   sx,
    input  cord_t   sy,
    input  cord_t   bx,
    input  cord_t   by,
    input  cord_t   p1y,
    input  cord_t   p2y,
    input  logic    hsync_in,
    input  logic    vsync_in,
    output logic    p1_col,
    output logic    p2_col,
    output logic    dvi_hsync,
    output logic    dvi_vsync,
    output logic    dvi_de,
    output colour_t dvi_r,
    output colour_t dvi_g,
    output colour_t dvi_b
);

    localparam colour_t white = '1;

    logic b_draw, p1_draw, p2_draw, lit;

    assign b_draw  = (sx >= bx) && (sx < bx + b_size) && (sy >= by) && (sy < by + b_size);
    assign p1_draw = (sx >= p_offs) && (sx < p_offs + p_w)
                  && (sy >= p1y) && (sy < p1y + p_h);
    assign p2_draw = (sx >= h_res - p_offs - p_w) && (sx < h_res - p_offs)
                  && (sy >= p2y) && (sy < p2y + p_h);
    assign lit     = de && (b_draw || p1_draw || p2_draw);

    // overlap seen this frame and read by the ball at the next animate
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            p1_col <= 1'b0;
            p2_col <= 1'b0;
        end else if (animate) begin
            p1_col <= 1'b0;
            p2_col <= 1'b0;
        end else if (b_draw) begin
            if (p1_draw) p1_col <= 1'b1;
            if (p2_draw) p2_col <= 1'b1;
        end
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            dvi_hsync <= 1'b1;
            dvi_vsync <= 1'b1;
            dvi_de    <= 1'b0;
            dvi_r     <= '0;
            dvi_g     <= '0;
            dvi_b     <= '0;
        end else begin
            dvi_hsync <= hsync_in;
            dvi_vsync <= vsync_in;
            dvi_de    <= de;
            dvi_r     <= lit ? white : '0;  // monochrome
            dvi_g     <= lit ? white : '0;
            dvi_b     <= lit ? white : '0;
        end
    end

endmodule

/* rtl/ball_motion.sv */
////////////////////////////////////////
// ball position, bounces, speed-up and
// left or right edge scoring
////////////////////////////////////////

module ball_motion import display_pkg::*, game_pkg::*; #(
    parameter int h_res      = 640,
    parameter int v_res      = 480,
    parameter int b_size     = 8,
    parameter int p_h        = 40,
    parameter int speed_step = 5
) (
    input  logic        clk_pix,
    input  logic        rst_n,
    input  logic        animate,
    input  logic        p1_col,
    input  logic        p2_col,
    input  game_state_t state,
    input  cord_t       p1y,
    output cord_t       bx,
    output cord_t       by,
    output logic        lft_col,
    output logic        rgt_col
);

    localparam cord_t bx_mid = cord_t'((h_res - b_size) / 2);
    localparam cord_t by_mid = cord_t'((v_res - b_size) / 2);
    localparam int    hit_w  = $clog2(speed_step + 1);
    localparam logic [hit_w-1:0] hit_last = hit_w'(speed_step - 1);

    speed_t           spx, spy;  // pixels per frame
    logic             dx, dy;    // 0 is right / down
    logic [hit_w-1:0] hit_cnt;   // hits since last speed-up

    // speed for demo and serve, then faster every speed_step hits
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            spx     <= speed_t'(6);
            spy     <= speed_t'(4);
            hit_cnt <= '0;
        end else if (state == INIT) begin
            spx     <= speed_t'(6);
            spy     <= speed_t'(4);
            hit_cnt <= '0;
        end else if (state == START) begin
            spx     <= speed_t'(4);
            spy     <= speed_t'(2);
            hit_cnt <= '0;
        end else if (state == PLAY && animate && (p1_col || p2_col)) begin
            if (hit_cnt == hit_last) begin
                spx     <= spx + 1'b1;
                spy     <= spy + 1'b1;
                hit_cnt <= '0;
            end else begin
                hit_cnt <= hit_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            bx      <= bx_mid;
            by      <= by_mid;
            dx      <= 1'b0;
            dy      <= 1'b0;
            lft_col <= 1'b0;
            rgt_col <= 1'b0;
        end else if (state == INIT || state == START) begin
            bx      <= bx_mid;
            by      <= by_mid;
            dx      <= 1'b0;  // serve towards paddle 2
            dy      <= ~dy;   // toggles until serve to vary the angle
            lft_col <= 1'b0;
            rgt_col <= 1'b0;
        end else if (animate && state != POINT_END) begin
            if (p1_col) begin
                dx <= 1'b0;
                bx <= bx + spx;
                dy <= (by + b_size/2 < p1y + p_h/2);  // upper half sends it up
            end else if (p2_col) begin
                dx <= 1'b1;
                bx <= bx - spx;
                dy <= (by + b_size/2 < p1y + p_h/2);
            end else if (bx >= h_res - (spx + b_size)) begin
                rgt_col <= 1'b1;
            end else if (bx < spx) begin
                lft_col <= 1'b1;
            end else begin
                bx <= dx ? bx - spx : bx + spx;
            end

            if (by >= v_res - (spy + b_size)) begin  // bottom edge
                dy <= 1'b1;
                by <= by - spy;
            end else if (by < spy) begin  // top edge
                dy <= 1'b0;
                by <= by + spy;
            end else begin
                by <= dy ? by - spy : by + spy;
            end
        end
    end

endmodule

/* rtl/paddle_motion.sv */
////////////////////////////////////////
// player and computer paddle positions
////////////////////////////////////////

module paddle_motion import display_pkg::*, game_pkg::*; #(
    parameter int v_res  = 480,
    parameter int p_h    = 40,
    parameter int p_sp   = 4,
    parameter int b_size = 8
) (
    input  logic        clk_pix,
    input  logic        rst_n,
    input  logic        animate,
    input  logic        move_up,
    input  logic        move_dn,
    input  game_state_t state,
    input  cord_t       by,
    output cord_t       p1y,
    output cord_t       p2y
);

    localparam cord_t p_mid = cord_t'((v_res - p_h) / 2);  // serve position
    localparam cord_t step  = cord_t'(p_sp);

    // computer control chases the ball centre with a half-step dead band
    function automatic cord_t follow(input cord_t py, input cord_t ball_y);
        cord_t res;
        res = py;
        if (py + p_h/2 + p_sp/2 < ball_y + b_size/2) begin
            if (py < v_res - (p_h + p_sp/2)) res = py + step;
        end else if (py + p_h/2 > ball_y + b_size/2 + p_sp/2) begin
            if (py > step) res = py - step;
        end
        return res;
    endfunction

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            p1y <= p_mid;
            p2y <= p_mid;
        end else if (state == INIT || state == START) begin
            p1y <= p_mid;
            p2y <= p_mid;
        end else if (animate && state != POINT_END) begin
            if (state == PLAY) begin  // player has paddle 1
                if (move_up && p1y > step) begin
                    p1y <= p1y - step;
                end else if (move_dn && p1y < v_res - (p_h + p_sp)) begin
                    p1y <= p1y + step;
                end
            end else begin  // demo
                p1y <= follow(p1y, by);
                p2y <= follow(p2y, by);
            end
        end
    end

endmodule

/* rtl/game_fsm.sv */
////////////////////////////////////////
// demo, serve, play and point sequencer
////////////////////////////////////////

module game_fsm import game_pkg::*; (
    input  logic        clk_pix,
    input  logic        rst_n,
    input  logic        ctrl_rel,
    input  logic        lft_col,
    input  logic        rgt_col,
    output game_state_t state
);

    game_state_t state_next;

    always_comb begin
        case (state)
            INIT:      state_next = IDLE;
            IDLE:      state_next = ctrl_rel ? START : IDLE;
            START:     state_next = ctrl_rel ? PLAY : START;
            PLAY:      state_next = (lft_col || rgt_col) ? POINT_END : PLAY;
            POINT_END: state_next = ctrl_rel ? START : POINT_END;
            default:   state_next = INIT;
        endcase
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            state <= INIT;
        end else begin
            state <= state_next;
        end
    end

endmodule

/* rtl/debounce.sv */
////////////////////////////////////////
// button synchroniser and debouncer
////////////////////////////////////////

module debounce #(
    parameter int deb_cycles = 2**17
) (
    input  logic clk_pix,
    input  logic rst_n,
    input  logic btn,
    output logic level,
    output logic rel
);

    localparam int cnt_w = $clog2(deb_cycles + 1);
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(deb_cycles - 1);

    logic             btn_q1, btn_q2;  // two-flop synchroniser
    logic [cnt_w-1:0] cnt;             // cycles the input has differed

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            btn_q1 <= 1'b0;
            btn_q2 <= 1'b0;
            cnt    <= '0;
            level  <= 1'b0;
            rel    <= 1'b0;
        end else begin
            btn_q1 <= btn;
            btn_q2 <= btn_q1;
            rel    <= 1'b0;
            if (btn_q2 == level) begin
                cnt <= '0;  // input back at the accepted level
            end else if (cnt == cnt_last) begin
                cnt   <= '0;
                level <= btn_q2;
                rel   <= level;  // falling accepted level
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

/* rtl/display_timings.sv */
////////////////////////////////////////
// raster counters with sync, data
// enable and the per-frame strobe
////////////////////////////////////////

module display_timings import display_pkg::*; #(
    parameter int h_res        = 640,
    parameter int v_res        = 480,
    parameter int h_full       = 800,
    parameter int v_full       = 525,
    parameter int h_sync_start = 656,
    parameter int h_sync_end   = 752,
    parameter int v_sync_start = 490,
    parameter int v_sync_end   = 492
) (
    input  logic  clk_pix,
    input  logic  rst_n,
    output cord_t sx,
    output cord_t sy,
    output logic  hsync,
    output logic  vsync,
    output logic  de,
    output logic  animate
);

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == cord_t'(h_full - 1)) begin
            sx <= '0;
            sy <= (sy == cord_t'(v_full - 1)) ? '0 : sy + 1'b1;  // next line
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // decoded straight from the counters
    assign hsync   = ~(sx >= h_sync_start && sx < h_sync_end);  // active low
    assign vsync   = ~(sy >= v_sync_start && sy < v_sync_end);
    assign de      = (sx < h_res) && (sy < v_res);
    assign animate = (sy == cord_t'(v_res)) && (sx == '0);  // start of vblank

endmodule

/* rtl/game_pkg.sv */
////////////////////////////////////////
// game sequencing and ball speed types
////////////////////////////////////////

package game_pkg;

    localparam int speed_w = 10;  // wide enough for any speed-up run

    // INIT is the reset state and lasts a single cycle
    typedef enum logic [2:0] {
        INIT,
        IDLE,       // demo with both paddles following the ball
        START,      // serve position held
        PLAY,
        POINT_END   // ball left the screen and all is frozen
    } game_state_t;

    // pixels moved per frame
    typedef logic [speed_w-1:0] speed_t;

endpackage

/* rtl/display_pkg.sv */
////////////////////////////////////////
// display types shared by the raster,
// motion and render blocks
////////////////////////////////////////

package display_pkg;

    localparam int cord_w   = 10;  // screen coordinate bits
    localparam int colour_w = 4;   // bits per colour channel

    // screen position, x or y
    typedef logic [cord_w-1:0] cord_t;

    // one channel of the 12-bit DVI colour
    typedef logic [colour_w-1:0] colour_t;

endpackage
